// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hw/decode_pkg.sv
  - hw/decode_control.sv
  - hw/register_file.sv
  - hw/imm_gen.sv
  - hw/alu_decoder.sv
  - hw/decode_stage.sv
  - target: test
    files:
      - tests/decode_stage_tb.sv

// ==== decode_stage.f ====
hw/decode_pkg.sv
hw/decode_control.sv
hw/register_file.sv
hw/imm_gen.sv
hw/alu_decoder.sv
hw/decode_stage.sv
tests/decode_stage_tb.sv

// ==== hw/alu_decoder.sv ====
`timescale 1ns/1ns

module alu_decoder (
    input  decode_pkg::alu_class_e  alu_class,
    input  logic [2:0]              funct3,
    input  logic                    funct7_5,
    output decode_pkg::alu_op_e     alu_op
);

    logic is_reg;

    // Bit 30 picks sub only for register ops
    assign is_reg = alu_class == decode_pkg::cls_reg;

    always_comb begin
        alu_op = decode_pkg::alu_add;
        case (alu_class)
            decode_pkg::cls_add: begin
                alu_op = decode_pkg::alu_add;
            end
            decode_pkg::cls_branch: begin
                alu_op = decode_pkg::alu_sub;
            end
            decode_pkg::cls_reg, decode_pkg::cls_imm: begin
                case (funct3)
                    3'b000: alu_op = (is_reg && funct7_5) ? decode_pkg::alu_sub
                                                          : decode_pkg::alu_add;
                    3'b001: alu_op = decode_pkg::alu_sll;
                    3'b010: alu_op = decode_pkg::alu_slt;
                    3'b011: alu_op = decode_pkg::alu_sltu;
                    3'b100: alu_op = decode_pkg::alu_xor;
                    3'b101: alu_op = funct7_5 ? decode_pkg::alu_sra : decode_pkg::alu_srl;
                    3'b110: alu_op = decode_pkg::alu_or;
                    default: alu_op = decode_pkg::alu_and;
                endcase
            end
            default: begin
                alu_op = decode_pkg::alu_add;
            end
        endcase
    end

endmodule

// ==== hw/decode_control.sv ====
`timescale 1ns/1ns

module decode_control (
    input  logic [31:0]             inst,
    input  decode_pkg::ex_hazard_t  ex_hazard,
    input  logic                    flush,
    input  logic                    predict_hit,
    output logic                    stall,
    output decode_pkg::ex_ctrl_t    ex_ctrl,
    output decode_pkg::alu_class_e  alu_class
);

    decode_pkg::opcode_e opcode;
    decode_pkg::ex_ctrl_t ctrl_raw;
    logic [decode_pkg::reg_idx_w-1:0] rs1;
    logic [decode_pkg::reg_idx_w-1:0] rs2;
    logic squash;

    assign opcode = decode_pkg::opcode_e'(inst[6:0]);
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    always_comb begin
        ctrl_raw = '0;
        alu_class = decode_pkg::cls_add;
        case (opcode)
            decode_pkg::op_load: begin
                ctrl_raw.alu_src = 1'b1;
                ctrl_raw.mem_read = 1'b1;
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.mem_to_reg = 1'b1;
            end
            decode_pkg::op_store: begin
                ctrl_raw.alu_src = 1'b1;
                ctrl_raw.mem_write = 1'b1;
            end
            decode_pkg::op_branch: begin
                ctrl_raw.branch = 1'b1;
                alu_class = decode_pkg::cls_branch;
            end
            decode_pkg::op_jal, decode_pkg::op_jalr: begin
                ctrl_raw.alu_src = 1'b1;
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.branch = 1'b1;
            end
            decode_pkg::op_lui, decode_pkg::op_auipc: begin
                ctrl_raw.alu_src = 1'b1;
                ctrl_raw.reg_write = 1'b1;
            end
            decode_pkg::op_op_imm: begin
                ctrl_raw.alu_src = 1'b1;
                ctrl_raw.reg_write = 1'b1;
                alu_class = decode_pkg::cls_imm;
            end
            decode_pkg::op_op: begin
                ctrl_raw.reg_write = 1'b1;
                alu_class = decode_pkg::cls_reg;
            end
            default: begin
                ctrl_raw = '0;
            end
        endcase
    end

    // Load-use hazard, x0 never stalls
    assign stall = ex_hazard.mem_read && (ex_hazard.rd != '0) &&
                   ((ex_hazard.rd == rs1) || (ex_hazard.rd == rs2));

    // Bubble on stall or on a mispredicted flush
    assign squash = stall || (flush && !predict_hit);
    assign ex_ctrl = squash ? '0 : ctrl_raw;

endmodule

// ==== hw/decode_pkg.sv ====
package decode_pkg;

    localparam int unsigned xlen = 32;
    localparam int unsigned reg_idx_w = 5;
    localparam int unsigned reg_count = 2 ** reg_idx_w;
    localparam logic [reg_idx_w-1:0] doorbell_reg = 5'd13;

    // RV32I major opcodes handled by this stage
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011
    } opcode_e;

    typedef enum logic [1:0] {
        cls_add    = 2'b00,
        cls_branch = 2'b01,
        cls_reg    = 2'b10,
        cls_imm    = 2'b11
    } alu_class_e;

    typedef enum logic [3:0] {
        alu_add      = 4'd0,
        alu_sub      = 4'd1,
        alu_sll      = 4'd2,
        alu_slt      = 4'd3,
        alu_sltu     = 4'd4,
        alu_xor      = 4'd5,
        alu_srl      = 4'd6,
        alu_sra      = 4'd7,
        alu_or       = 4'd8,
        alu_and      = 4'd9,
        alu_lui_pass = 4'd10
    } alu_op_e;

    // Flags consumed by the execute stage
    typedef struct packed {
        logic alu_src;
        logic mem_read;
        logic mem_write;
        logic reg_write;
        logic mem_to_reg;
        logic branch;
    } ex_ctrl_t;

    typedef struct packed {
        logic                 reg_write;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } wb_port_t;

    typedef struct packed {
        logic                 mem_read;
        logic [reg_idx_w-1:0] rd;
    } ex_hazard_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [7:0]      paddr;
        logic [xlen-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [xlen-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

endpackage

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                        clk_50,
    input  logic                        rst,
    input  logic [31:0]                 inst,
    input  decode_pkg::wb_port_t        wb,
    input  decode_pkg::ex_hazard_t      ex_hazard,
    input  logic                        flush,
    input  logic                        predict_hit,
    input  logic                        npu_ack,
    input  decode_pkg::apb_req_t        apb_req,
    output decode_pkg::apb_rsp_t        apb_rsp,
    output logic [decode_pkg::xlen-1:0] rs1_data,
    output logic [decode_pkg::xlen-1:0] rs2_data,
    output logic [decode_pkg::xlen-1:0] imm,
    output decode_pkg::ex_ctrl_t        ex_ctrl,
    output decode_pkg::alu_op_e         alu_op,
    output logic                        stall,
    output logic                        npu_start
);

    decode_pkg::alu_class_e alu_class;

    decode_control u_control (
        .inst        (inst),
        .ex_hazard   (ex_hazard),
        .flush       (flush),
        .predict_hit (predict_hit),
        .stall       (stall),
        .ex_ctrl     (ex_ctrl),
        .alu_class   (alu_class)
    );

    register_file u_regs (
        .clk_50    (clk_50),
        .rst       (rst),
        .rs1       (inst[19:15]),
        .rs2       (inst[24:20]),
        .wb        (wb),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .npu_ack   (npu_ack),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .npu_start (npu_start)
    );

    imm_gen u_imm (
        .inst (inst),
        .imm  (imm)
    );

    alu_decoder u_alu_dec (
        .alu_class (alu_class),
        .funct3    (inst[14:12]),
        .funct7_5  (inst[30]),
        .alu_op    (alu_op)
    );

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ns

module imm_gen (
    input  logic [31:0]                 inst,
    output logic [decode_pkg::xlen-1:0] imm
);

    decode_pkg::opcode_e opcode;
    logic sign;

    assign opcode = decode_pkg::opcode_e'(inst[6:0]);
    assign sign = inst[31];

    always_comb begin
        case (opcode)
            // I format
            decode_pkg::op_load, decode_pkg::op_jalr, decode_pkg::op_op_imm: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            decode_pkg::op_store: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            decode_pkg::op_branch: begin
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            decode_pkg::op_lui, decode_pkg::op_auipc: begin
                imm = {inst[31:12], 12'b0};
            end
            decode_pkg::op_jal: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic                                clk_50,
    input  logic                                rst,
    input  logic [decode_pkg::reg_idx_w-1:0]    rs1,
    input  logic [decode_pkg::reg_idx_w-1:0]    rs2,
    input  decode_pkg::wb_port_t                wb,
    input  decode_pkg::apb_req_t                apb_req,
    output decode_pkg::apb_rsp_t                apb_rsp,
    input  logic                                npu_ack,
    output logic [decode_pkg::xlen-1:0]         rs1_data,
    output logic [decode_pkg::xlen-1:0]         rs2_data,
    output logic                                npu_start
);

    logic [decode_pkg::xlen-1:0] regs [decode_pkg::reg_count];
    logic [decode_pkg::reg_idx_w-1:0] apb_idx;
    logic apb_access;
    logic apb_misaligned;
    logic apb_wr_en;
    logic wb_wr_en;
    logic ring;

    assign wb_wr_en = wb.reg_write && (wb.rd != '0);

    // Read ports with writeback bypass
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (wb.reg_write && (wb.rd == rs1)) begin
            rs1_data = wb.data;
        end else begin
            rs1_data = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (wb.reg_write && (wb.rd == rs2)) begin
            rs2_data = wb.data;
        end else begin
            rs2_data = regs[rs2];
        end
    end

    // Debug port, writeback holds it off
    assign apb_idx = apb_req.paddr[6:2];
    assign apb_access = apb_req.psel && apb_req.penable;
    assign apb_misaligned = apb_req.paddr[1:0] != 2'b00;
    assign apb_rsp.pready = apb_access && !wb.reg_write;
    assign apb_rsp.pslverr = apb_rsp.pready && apb_misaligned;
    assign apb_rsp.prdata = apb_access ? regs[apb_idx] : '0;
    assign apb_wr_en = apb_rsp.pready && apb_req.pwrite && !apb_misaligned &&
                       (apb_idx != '0);

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < decode_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wr_en) begin
            regs[wb.rd] <= wb.data;
        end else if (apb_wr_en) begin
            regs[apb_idx] <= apb_req.pwdata;
        end
    end

    assign ring = wb.reg_write && (wb.rd == decode_pkg::doorbell_reg) && (wb.data != '0);

    // Accelerator doorbell, ack wins
    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            npu_start <= 1'b0;
        end else if (npu_ack) begin
            npu_start <= 1'b0;
        end else if (ring) begin
            npu_start <= 1'b1;
        end
    end

endmodule

// ==== tests/decode_stage_tb.sv ====
`timescale 1ns/1ns

module decode_stage_tb;

    // Tests need roughly 400 cycles
    localparam int timeout_cycles = 2000;

    logic clk_50;
    logic rst;
    logic [31:0] inst;
    decode_pkg::wb_port_t wb;
    decode_pkg::ex_hazard_t ex_hazard;
    logic flush;
    logic predict_hit;
    logic npu_ack;
    decode_pkg::apb_req_t apb_req;
    decode_pkg::apb_rsp_t apb_rsp;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    decode_pkg::ex_ctrl_t ex_ctrl;
    decode_pkg::alu_op_e alu_op;
    logic stall;
    logic npu_start;
    logic [31:0] seed = 32'h232b3b4d;
    logic [31:0] model [32];
    int cycles = 0;

    decode_stage uut (.*);

    initial begin
        clk_50 = 1'b0;
        forever #10 clk_50 = ~clk_50;
    end

    always @(posedge clk_50) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycles);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function logic [31:0] rand_word();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, 5'd1, 7'b0110011};
    endfunction

    // Operation rule for register and immediate ALU instructions
    function automatic decode_pkg::alu_op_e expected_alu(input logic is_reg,
                                                         input logic [2:0] f3, input logic b30);
        decode_pkg::alu_op_e op;
        case (f3)
            3'd0: op = decode_pkg::alu_add;
            3'd1: op = decode_pkg::alu_sll;
            3'd2: op = decode_pkg::alu_slt;
            3'd3: op = decode_pkg::alu_sltu;
            3'd4: op = decode_pkg::alu_xor;
            3'd5: op = decode_pkg::alu_srl;
            3'd6: op = decode_pkg::alu_or;
            default: op = decode_pkg::alu_and;
        endcase
        // Bit 30 gives sub for register adds and sra for both shift forms
        if (b30 && (f3 == 3'd0) && is_reg)
            op = decode_pkg::alu_sub;
        if (b30 && (f3 == 3'd5))
            op = decode_pkg::alu_sra;
        return op;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", what, act, exp));
    endtask

    task automatic check_ctrl(input decode_pkg::ex_ctrl_t act, input decode_pkg::ex_ctrl_t exp,
                              input string what);
        if (act !== exp)
            report_mismatch($sformatf("%s are %b, expected %b", what, act, exp));
    endtask

    task automatic check_alu(input decode_pkg::alu_op_e act, input decode_pkg::alu_op_e exp,
                             input string what);
        if (act !== exp)
            report_mismatch($sformatf("%s is %0d, expected %0d", what, act, exp));
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, act, exp));
    endtask

    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(negedge clk_50);
        apb_req = {1'b1, 1'b0, wr, addr, wdata};
        @(negedge clk_50);
        apb_req.penable = 1'b1;
        do @(posedge clk_50); while (!apb_rsp.pready);
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(negedge clk_50);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic present(input logic [31:0] word, input logic [5:0] hazard, input logic fl,
                           input logic hit);
        @(negedge clk_50);
        inst = word;
        ex_hazard = hazard;
        flush = fl;
        predict_hit = hit;
        @(posedge clk_50);
    endtask

    task automatic present_inst(input logic [31:0] word);
        present(word, 6'h00, 1'b0, 1'b0);
    endtask

    task automatic writeback(input logic [4:0] rd, input logic [31:0] data, input logic ack);
        @(negedge clk_50);
        wb = {1'b1, rd, data};
        npu_ack = ack;
        @(negedge clk_50);
        wb = '0;
        npu_ack = 1'b0;
        if (rd != 5'd0)
            model[rd] = data;
    endtask

    task automatic test_registers();
        logic [31:0] data;
        logic err;
        for (int i = 1; i < 32; i++) begin
            model[i] = rand_word();
            apb_write(8'(i * 4), model[i], err);
            check_bit(err, 1'b0, "pslverr on aligned write");
        end
        // x0 must ignore this
        apb_write(8'h00, rand_word(), err);
        for (int i = 0; i < 32; i++) begin
            present_inst(r_type(5'(i), 5'(31 - i)));
            check_word(rs1_data, model[i], "rs1 read port");
            check_word(rs2_data, model[31 - i], "rs2 read port");
            apb_read(8'(i * 4), data, err);
            check_word(data, model[i], "APB read data");
            check_bit(err, 1'b0, "pslverr on aligned read");
        end
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        logic [12:0] b;
        logic [20:0] j;
        logic [6:0] op;
        for (int n = 0; n < 9; n++) begin
            r = rand_word();
            op = (n % 3 == 0) ? decode_pkg::op_load :
                 (n % 3 == 1) ? decode_pkg::op_jalr : decode_pkg::op_op_imm;
            present_inst({r[11:0], 5'd1, 3'b000, 5'd2, op});
            check_word(imm, {{20{r[11]}}, r[11:0]}, "I immediate");
            present_inst({r[11:5], 5'd3, 5'd1, 3'b010, r[4:0], 7'b0100011});
            check_word(imm, {{20{r[11]}}, r[11:0]}, "S immediate");
            b = {r[12:1], 1'b0};
            present_inst({b[12], b[10:5], 5'd3, 5'd1, 3'b000, b[4:1], b[11], 7'b1100011});
            check_word(imm, {{19{b[12]}}, b}, "B immediate");
            present_inst({r[31:12], 5'd1, 7'b0110111});
            check_word(imm, {r[31:12], 12'h000}, "U immediate");
            j = {r[20:1], 1'b0};
            present_inst({j[20], j[10:1], j[11], j[19:12], 5'd1, 7'b1101111});
            check_word(imm, {{11{j[20]}}, j}, "J immediate");
        end
    endtask

    task automatic decode_case(input logic [31:0] word, input logic [5:0] flags,
                               input decode_pkg::alu_op_e exp_alu);
        present_inst(word);
        check_ctrl(ex_ctrl, decode_pkg::ex_ctrl_t'(flags), "execute flags");
        check_alu(alu_op, exp_alu, "ALU operation");
    endtask

    task automatic test_control();
        logic [31:0] r;
        r = rand_word();
        // Flags in order alu_src, mem_read, mem_write, reg_write, mem_to_reg, branch
        decode_case({r[31:7], decode_pkg::op_load}, 6'b110110, decode_pkg::alu_add);
        decode_case({r[31:7], decode_pkg::op_store}, 6'b101000, decode_pkg::alu_add);
        decode_case({r[31:7], decode_pkg::op_branch}, 6'b000001, decode_pkg::alu_sub);
        decode_case({r[31:7], decode_pkg::op_jal}, 6'b100101, decode_pkg::alu_add);
        decode_case({r[31:7], decode_pkg::op_jalr}, 6'b100101, decode_pkg::alu_add);
        decode_case({r[31:7], decode_pkg::op_lui}, 6'b100100, decode_pkg::alu_add);
        decode_case({r[31:7], decode_pkg::op_auipc}, 6'b100100, decode_pkg::alu_add);
        decode_case({r[31:7], 7'b1110011}, 6'b000000, decode_pkg::alu_add);
        for (int k = 0; k < 16; k++) begin
            decode_case({1'b0, k[3], 5'd0, r[24:15], k[2:0], 5'd1, decode_pkg::op_op},
                        6'b000100, expected_alu(1'b1, k[2:0], k[3]));
            decode_case({1'b0, k[3], 5'd0, r[24:15], k[2:0], 5'd1, decode_pkg::op_op_imm},
                        6'b100100, expected_alu(1'b0, k[2:0], k[3]));
        end
    endtask

    task automatic squash_case(input logic [31:0] word, input logic [5:0] hazard,
                               input logic fl, input logic hit, input logic exp_stall,
                               input logic [5:0] flags);
        present(word, hazard, fl, hit);
        check_bit(stall, exp_stall, "stall");
        check_ctrl(ex_ctrl, decode_pkg::ex_ctrl_t'(flags), "execute flags");
    endtask

    task automatic test_squash();
        squash_case(r_type(5'd5, 5'd6), {1'b1, 5'd5}, 1'b0, 1'b0, 1'b1, 6'b000000);
        squash_case(r_type(5'd5, 5'd6), {1'b1, 5'd6}, 1'b0, 1'b0, 1'b1, 6'b000000);
        squash_case(r_type(5'd0, 5'd6), {1'b1, 5'd0}, 1'b0, 1'b0, 1'b0, 6'b000100);
        squash_case(r_type(5'd5, 5'd6), {1'b1, 5'd9}, 1'b0, 1'b0, 1'b0, 6'b000100);
        squash_case(r_type(5'd5, 5'd6), {1'b0, 5'd5}, 1'b0, 1'b0, 1'b0, 6'b000100);
        squash_case(r_type(5'd5, 5'd6), 6'h00, 1'b1, 1'b0, 1'b0, 6'b000000);
        squash_case(r_type(5'd5, 5'd6), 6'h00, 1'b1, 1'b1, 1'b0, 6'b000100);
        present_inst(r_type(5'd5, 5'd6));
    endtask

    task automatic test_doorbell();
        logic [31:0] v;
        v = rand_word();
        writeback(5'd13, v, 1'b0);
        check_bit(npu_start, 1'b1, "npu_start after nonzero write to x13");
        @(negedge clk_50);
        npu_ack = 1'b1;
        @(negedge clk_50);
        npu_ack = 1'b0;
        check_bit(npu_start, 1'b0, "npu_start after ack");
        writeback(5'd13, 32'h0, 1'b0);
        check_bit(npu_start, 1'b0, "npu_start after zero write to x13");
        writeback(5'd12, v, 1'b0);
        check_bit(npu_start, 1'b0, "npu_start after write to x12");
        writeback(5'd13, v, 1'b0);
        check_bit(npu_start, 1'b1, "npu_start after second write to x13");
        writeback(5'd13, rand_word(), 1'b1);
        check_bit(npu_start, 1'b0, "npu_start after ack with a new write");
    endtask

    task automatic test_wb_apb();
        logic [31:0] v;
        logic [31:0] data;
        logic err;
        v = rand_word();
        @(negedge clk_50);
        inst = r_type(5'd20, 5'd21);
        wb = {1'b1, 5'd20, v};
        @(posedge clk_50);
        check_word(rs1_data, v, "bypassed rs1 data");
        check_word(rs2_data, model[21], "rs2 data beside a writeback");
        model[20] = v;
        v = rand_word();
        // Read of x5 while the pipeline writes it
        @(negedge clk_50);
        wb = {1'b1, 5'd5, v};
        apb_req = {3'b100, 8'd20, 32'h0};
        @(negedge clk_50);
        apb_req.penable = 1'b1;
        @(posedge clk_50);
        check_bit(apb_rsp.pready, 1'b0, "pready during writeback");
        @(negedge clk_50);
        wb = '0;
        model[5] = v;
        @(posedge clk_50);
        check_bit(apb_rsp.pready, 1'b1, "pready after writeback");
        check_word(apb_rsp.prdata, model[5], "APB read after writeback");
        @(negedge clk_50);
        apb_req = '0;
        apb_write(8'd90, rand_word(), err);
        check_bit(err, 1'b1, "pslverr on misaligned write");
        apb_read(8'd88, data, err);
        check_word(data, model[22], "x22 after misaligned write");
    endtask

    initial begin
        rst = 1'b1;
        inst = '0;
        wb = '0;
        ex_hazard = '0;
        flush = 1'b0;
        predict_hit = 1'b0;
        npu_ack = 1'b0;
        apb_req = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        repeat (3) @(posedge clk_50);
        @(negedge clk_50);
        rst = 1'b0;
        check_bit(npu_start, 1'b0, "npu_start after reset");
        check_bit(apb_rsp.pready, 1'b0, "pready after reset");
        test_registers();
        test_immediates();
        test_control();
        test_squash();
        test_doorbell();
        test_wb_apb();
        $display("=== PASS ===");
        $finish;
    end

endmodule
